// File: rtl/cpu_settings.svh
// width settings for the decode/execute slice; include wherever a bus is sized.
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path word.
`define DATA_WIDTH 16

// register number, eight registers.
`define REG_ADDR_WIDTH 3

// raw immediate field of the I format.
`define IMM_WIDTH 5

`endif

// File: rtl/cpuPkg.sv
// shared types for the decode/execute slice: instruction formats, opcodes and stage bundles.
`include "cpu_settings.svh"

package cpuPkg;

	typedef struct packed {
		logic [4:0] opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [1:0] func;
	} rFmtT;

	typedef struct packed {
		logic [4:0] opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`IMM_WIDTH-1:0] imm;
	} iFmtT;

	// one fetched word, read as R or I format depending on the opcode.
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
	} instrWord;

	localparam logic [4:0] opNop  = 5'b00000;
	localparam logic [4:0] opHalt = 5'b00001;
	localparam logic [4:0] opAddi = 5'b01000;
	localparam logic [4:0] opAndi = 5'b01011;
	localparam logic [4:0] opBeqz = 5'b01100;
	localparam logic [4:0] opBnez = 5'b01101;
	localparam logic [4:0] opAlu  = 5'b11011; // R format, func picks the operation.

	localparam logic [1:0] fnAdd = 2'b00;
	localparam logic [1:0] fnSub = 2'b01;
	localparam logic [1:0] fnAnd = 2'b10;
	localparam logic [1:0] fnXor = 2'b11;

	localparam logic [1:0] lopAdd = 2'b00;
	localparam logic [1:0] lopAnd = 2'b01;
	localparam logic [1:0] lopXor = 2'b10;

	typedef struct packed {
		logic aluSrc; // second operand is the immediate.
		logic invB;
		logic cin;
		logic [1:0] logicOp;
		logic branch;
		logic branchNz; // branch when rs is nonzero.
		logic regWrEn;
		logic halt;
	} deCtrl;

	typedef struct packed {
		deCtrl ctrl;
		logic [`DATA_WIDTH-1:0] opA;
		logic [`DATA_WIDTH-1:0] opB;
		logic [`DATA_WIDTH-1:0] imm;
		logic [`DATA_WIDTH-1:0] incPc;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
	} deBundle;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] result;
		logic [`DATA_WIDTH-1:0] target;
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
		logic regWrEn;
		logic branchTaken;
		logic halt;
	} exOut;

endpackage

// File: rtl/instDecode.sv
// instruction decoder; turns a fetched word into control bits, register numbers and an immediate.
`timescale 1ns/10ps
`include "cpu_settings.svh"

module instDecode (
	input cpuPkg::instrWord instr,
	output cpuPkg::deCtrl ctrl,
	output logic [`REG_ADDR_WIDTH-1:0] rs,
	output logic [`REG_ADDR_WIDTH-1:0] rt,
	output logic [`REG_ADDR_WIDTH-1:0] writeReg,
	output logic [`DATA_WIDTH-1:0] imm
);

	logic isRFmt;
	logic legal;
	logic [4:0] opcode;

	assign opcode = instr.rFmt.opcode; // same bits in both views.
	assign isRFmt = (opcode == cpuPkg::opAlu);

	assign rs = instr.iFmt.rs; // rs sits in the same place in both formats.
	assign rt = instr.rFmt.rt;
	assign writeReg = isRFmt ? instr.rFmt.rd : instr.iFmt.rd;
	assign imm = {{(`DATA_WIDTH-`IMM_WIDTH){instr.iFmt.imm[`IMM_WIDTH-1]}}, instr.iFmt.imm};

	always_comb begin
		ctrl = '0;
		legal = 1'b1;
		case (opcode)
			cpuPkg::opNop: begin
				ctrl = '0;
			end
			cpuPkg::opHalt: begin
				ctrl.halt = 1'b1;
			end
			cpuPkg::opAlu: begin
				ctrl.regWrEn = 1'b1;
				case (instr.rFmt.func)
					cpuPkg::fnSub: begin
						ctrl.invB = 1'b1; // a + ~b + 1.
						ctrl.cin = 1'b1;
					end
					cpuPkg::fnAnd: ctrl.logicOp = cpuPkg::lopAnd;
					cpuPkg::fnXor: ctrl.logicOp = cpuPkg::lopXor;
					default: ctrl.logicOp = cpuPkg::lopAdd;
				endcase
			end
			cpuPkg::opAddi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrEn = 1'b1;
			end
			cpuPkg::opAndi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrEn = 1'b1;
				ctrl.logicOp = cpuPkg::lopAnd;
			end
			cpuPkg::opBeqz: begin
				ctrl.branch = 1'b1;
			end
			cpuPkg::opBnez: begin
				ctrl.branch = 1'b1;
				ctrl.branchNz = 1'b1;
			end
			default: begin
				legal = 1'b0; // unknown opcode goes down as a bubble.
			end
		endcase
	end

	// an unknown opcode silently becomes a bubble further down the pipe.
	always_comb begin
		assert ($isunknown(opcode) || legal)
			else $warning("instDecode: unknown opcode %b", opcode);
	end

endmodule

// File: rtl/regFile.sv
// register file, eight registers with two combinational reads and one clocked write-back port.
`timescale 1ns/10ps
`include "cpu_settings.svh"

module regFile (
	input logic clk,
	input logic rstN,
	input logic [`REG_ADDR_WIDTH-1:0] rs,
	input logic [`REG_ADDR_WIDTH-1:0] rt,
	output logic [`DATA_WIDTH-1:0] opA,
	output logic [`DATA_WIDTH-1:0] opB,
	input logic wbEn,
	input logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input logic [`DATA_WIDTH-1:0] wbData
);

	logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbReg] <= wbData;
		end
	end

	// no bypass, a same-cycle write shows up on the next read.
	assign opA = regs[rs];
	assign opB = regs[rt];

endmodule

// File: rtl/pipeDe.sv
// decode/execute pipeline register; holds on stall, loads a bubble on flush or reset.
`timescale 1ns/10ps

module pipeDe (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input cpuPkg::deBundle d,
	output cpuPkg::deBundle q
);

	always_ff @(posedge clk) begin
		if (!stall) begin
			q <= d;
		end
		if (!rstN || flush) begin
			q.ctrl <= '0; // bubble, flush wins over stall.
		end
	end

	// a stalled stage must present the same bundle to execute on the next cycle.
	assert property (@(posedge clk) (stall && !flush && rstN) |=> $stable(q))
		else $error("pipeDe: bundle changed while stalled");

endmodule

// File: rtl/execStage.sv
// execute stage; ALU with operand select and invert, plus branch condition and target.
`timescale 1ns/10ps
`include "cpu_settings.svh"

module execStage (
	input cpuPkg::deBundle de,
	output cpuPkg::exOut ex
);

	logic [`DATA_WIDTH-1:0] bSel;
	logic [`DATA_WIDTH-1:0] bOp;
	logic [`DATA_WIDTH-1:0] sum;
	logic aZero;

	assign bSel = de.ctrl.aluSrc ? de.imm : de.opB;
	assign bOp = de.ctrl.invB ? ~bSel : bSel;
	assign sum = de.opA + bOp + {{(`DATA_WIDTH-1){1'b0}}, de.ctrl.cin};
	assign aZero = (de.opA == '0);

	always_comb begin
		case (de.ctrl.logicOp)
			cpuPkg::lopAnd: ex.result = de.opA & bOp;
			cpuPkg::lopXor: ex.result = de.opA ^ bOp;
			default: ex.result = sum;
		endcase
		ex.target = de.incPc + de.imm; // pc-relative.
		ex.writeReg = de.writeReg;
		ex.regWrEn = de.ctrl.regWrEn;
		ex.branchTaken = de.ctrl.branch && (de.ctrl.branchNz ? !aZero : aZero);
		ex.halt = de.ctrl.halt;
	end

	// decode never marks a branch as writing a register.
	always_comb begin
		assert (!(ex.regWrEn === 1'b1 && ex.branchTaken === 1'b1))
			else $error("execStage: branch taken with register write enabled");
	end

endmodule

// File: rtl/decodeExecTop.sv
// top of the decode/execute slice; decoder, register file, pipeline register and execute stage.
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decodeExecTop (
	input logic clk,
	input logic rstN,
	input cpuPkg::instrWord instr,
	input logic [`DATA_WIDTH-1:0] incPc,
	input logic stall,
	input logic flush,
	input logic wbEn,
	input logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input logic [`DATA_WIDTH-1:0] wbData,
	output cpuPkg::exOut ex
);

	cpuPkg::deCtrl decCtrl;
	logic [`REG_ADDR_WIDTH-1:0] rs;
	logic [`REG_ADDR_WIDTH-1:0] rt;
	logic [`REG_ADDR_WIDTH-1:0] writeReg;
	logic [`DATA_WIDTH-1:0] imm;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	cpuPkg::deBundle deD;
	cpuPkg::deBundle deQ;

	instDecode instDecode_inst (
		.instr(instr),
		.ctrl(decCtrl),
		.rs(rs),
		.rt(rt),
		.writeReg(writeReg),
		.imm(imm)
	);

	regFile regFile_inst (
		.clk(clk),
		.rstN(rstN),
		.rs(rs),
		.rt(rt),
		.opA(opA),
		.opB(opB),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	assign deD = '{ctrl: decCtrl, opA: opA, opB: opB, imm: imm, incPc: incPc,
		rs: rs, writeReg: writeReg};

	pipeDe pipeDe_inst (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.flush(flush),
		.d(deD),
		.q(deQ)
	);

	execStage execStage_inst (
		.de(deQ),
		.ex(ex)
	);

endmodule

// File: sim/tbClock.sv
// clock and reset source for the testbench; 100 ns clock, rstN held low for the first 16 edges.
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1; // released on the 16th rising edge.
	end

	always #50 clk = ~clk;

endmodule

// File: sim/decodeExecTb.sv
// testbench for the decode/execute slice; replays sim/deStim.txt cycle by cycle and checks ex.
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decodeExecTb;

	localparam int numLines = 21;
	localparam int lineWords = 9; // hex words per stimulus line.
	localparam int resetTimeout = 40;
	localparam int haltTimeout = 20;
	localparam int holdCheck = -1;
	localparam int noCheck = -2;

	logic clk;
	logic rstN;
	cpuPkg::instrWord instr;
	logic [`DATA_WIDTH-1:0] incPc;
	logic stall;
	logic flush;
	logic wbEn;
	logic [`REG_ADDR_WIDTH-1:0] wbReg;
	logic [`DATA_WIDTH-1:0] wbData;
	cpuPkg::exOut ex;

	logic [15:0] stim [numLines*lineWords];
	cpuPkg::exOut lastEx;
	int errors;
	int checks;
	int pending; // line whose result shows at the next negedge, or a hold check.
	int waitCnt;
	integer seed;

	tbClock tbClock_inst (
		.clk(clk),
		.rstN(rstN)
	);

	decodeExecTop decodeExecTop_inst (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.incPc(incPc),
		.stall(stall),
		.flush(flush),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.ex(ex)
	);

	task automatic compareField(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkLine(input int i);
		logic [15:0] ctl;
		logic [15:0] flags;
		ctl = stim[i*lineWords+2];
		flags = stim[i*lineWords+7];
		compareField("ex.regWrEn", ex.regWrEn, flags[8]);
		compareField("ex.branchTaken", ex.branchTaken, flags[4]);
		compareField("ex.halt", ex.halt, flags[0]);
		if (ctl[0]) begin
			compareField("ex.result", ex.result, stim[i*lineWords+5]);
			compareField("ex.writeReg", ex.writeReg, stim[i*lineWords+6]);
		end
		if (ctl[1]) begin
			compareField("ex.target", ex.target, stim[i*lineWords+8]);
		end
	endtask

	task automatic checkPending();
		if (pending == holdCheck) begin
			checks++;
			if (ex !== lastEx) begin
				errors++;
				$display("error at %0t: ex is %h, expected held value %h", $time, ex, lastEx);
			end
		end else if (pending >= 0) begin
			checkLine(pending);
		end
		lastEx = ex;
	endtask

	task automatic driveLine(input int i);
		logic [15:0] ctl;
		ctl = stim[i*lineWords+2];
		instr <= stim[i*lineWords];
		incPc <= stim[i*lineWords+1];
		stall <= ctl[12];
		flush <= ctl[8];
		wbEn <= ctl[4];
		wbReg <= stim[i*lineWords+3][`REG_ADDR_WIDTH-1:0];
		wbData <= stim[i*lineWords+4];
	endtask

	// stalled cycle with a random ALU word at the input.
	task automatic driveFiller();
		logic [31:0] r;
		r = $random(seed);
		instr <= {cpuPkg::opAlu, r[10:0]};
		incPc <= r[31:16];
		stall <= 1'b1;
		flush <= 1'b0;
		wbEn <= 1'b0;
	endtask

	task automatic runStimulus();
		int fill;
		for (int i = 0; i < numLines; i++) begin
			@(posedge clk);
			driveLine(i);
			@(negedge clk);
			checkPending();
			pending = i;
			if (i < numLines - 1) begin
				fill = {$random(seed)} % 3;
				repeat (fill) begin
					@(posedge clk);
					driveFiller();
					@(negedge clk);
					checkPending();
					pending = holdCheck;
				end
			end
		end
		@(posedge clk);
		driveFiller(); // keeps the halt in the pipeline register.
		waitCnt = 0;
		@(negedge clk);
		while (ex.halt !== 1'b1 && waitCnt < haltTimeout) begin
			@(negedge clk);
			waitCnt++;
		end
		if (ex.halt !== 1'b1) begin
			errors++;
			$display("halt did not reach ex within %0d cycles", haltTimeout);
		end else begin
			checkPending();
		end
	endtask

	initial begin
		instr = {cpuPkg::opHalt, 11'b0}; // live control word, only reset can bubble it.
		incPc = '0;
		stall = 1'b0;
		flush = 1'b0;
		wbEn = 1'b0;
		wbReg = '0;
		wbData = '0;
		errors = 0;
		checks = 0;
		pending = noCheck;
		lastEx = '0;
		seed = 32'h95b20225;
		$readmemh("sim/deStim.txt", stim);
		waitCnt = 0;
		while (rstN !== 1'b1 && waitCnt < resetTimeout) begin
			@(negedge clk);
			waitCnt++;
		end
		if (rstN !== 1'b1) begin
			errors++;
			$display("reset was not released within %0d cycles", resetTimeout);
		end else begin
			checks++;
			if (ex.regWrEn !== 1'b0 || ex.branchTaken !== 1'b0 || ex.halt !== 1'b0) begin
				errors++;
				$display("error at %0t: ex flags are %b%b%b after reset, expected 000",
					$time, ex.regWrEn, ex.branchTaken, ex.halt);
			end
			runStimulus();
		end
		$display("decodeExecTb: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: sim/deStim.txt
// instr incPc ctl(stall flush wbEn check) wbReg wbData, then expected result writeReg
// flags(regWrEn branchTaken halt) target; check bit0 = result and writeReg, bit1 = target
0000 0001 0010 1 1234 0000 0 000 0000
0000 0002 0010 2 0f0f 0000 0 000 0000
0000 0003 0010 4 0005 0000 0 000 0000
d954 0010 0001 0 0000 2143 5 100 0000
d959 0011 0001 0 0000 0325 6 100 0000
d95e 0012 0011 5 2143 0204 7 100 0000
d94f 0013 0001 0 0000 1d3b 3 100 0000
dd98 0014 0001 0 0000 2148 6 100 0000
415d 0100 0003 0 0000 1231 2 100 00fd
5af0 0110 0001 0 0000 0f00 7 100 0000
6306 0020 0002 0 0000 0000 0 010 0026
6118 0030 0002 0 0000 0000 0 000 0028
6a04 0040 0002 0 0000 0000 0 010 0044
6b1f 0050 0002 0 0000 0000 0 000 004f
415d 0060 0003 0 0000 1231 2 100 005d
5af0 0070 1003 0 0000 1231 2 100 005d
d94f 0071 1003 0 0000 1231 2 100 005d
d954 0072 1100 0 0000 0000 0 000 0000
415d 0073 0100 0 0000 0000 0 000 0000
5af0 0080 0003 0 0000 0f00 7 100 0070
0800 0090 0000 0 0000 0000 0 001 0000

// File: list.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/instDecode.sv
rtl/regFile.sv
rtl/pipeDe.sv
rtl/execStage.sv
rtl/decodeExecTop.sv
sim/tbClock.sv
sim/decodeExecTb.sv

// File: run.sh
#!/bin/sh
# builds and runs the testbench with Verilator; a fail message or missing pass line fails the run
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module decodeExecTb -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	; cat sim.log \
	&& ! grep -q "Simulation FAILED" sim.log \
	&& grep -q "Simulation PASSED" sim.log \
	|| { echo "run failed"; exit 1; }
